/* fetch_pkg.sv */
package fetch_pkg;

    // Instructions fetched per cycle
    localparam int FETCH_WIDTH = 2;

    typedef logic [31:0] ADDR;
    typedef logic [31:0] INST;
    typedef logic [63:0] MEM_BLOCK;

    // Zero means no transaction
    typedef logic [3:0] MEM_TAG;

    typedef enum logic [1:0] {
        NONE  = 2'h0,
        LOAD  = 2'h1,
        STORE = 2'h2
    } MEM_COMMAND;

    // addi x0, x0, 0
    localparam INST NOP = 32'h0000_0013;

    // Instruction cache geometry, two instructions per block
    localparam int BLOCK_OFFSET_BITS = 3;
    localparam int ICACHE_LINES      = 32;
    localparam int ICACHE_INDEX_BITS = $clog2(ICACHE_LINES);
    localparam int ICACHE_TAG_BITS   = 32 - BLOCK_OFFSET_BITS - ICACHE_INDEX_BITS;

    typedef logic [ICACHE_INDEX_BITS-1:0] ICACHE_INDEX;
    typedef logic [ICACHE_TAG_BITS-1:0]   ICACHE_TAG;

    localparam int IMSHR_SIZE       = 4;
    localparam int IMSHR_INDEX_BITS = $clog2(IMSHR_SIZE);

    // Predictor tables, indexed by word address bits
    localparam int BTB_SIZE       = 16;
    localparam int BHT_SIZE       = 16;
    localparam int PHT_SIZE       = 16;
    localparam int BHT_WIDTH      = 4;
    localparam int BTB_INDEX_BITS = $clog2(BTB_SIZE);
    localparam int BTB_TAG_BITS   = 30 - BTB_INDEX_BITS;
    localparam int BHT_INDEX_BITS = $clog2(BHT_SIZE);

    typedef enum logic [1:0] {
        STRONG_NT = 2'h0,
        WEAK_NT   = 2'h1,
        WEAK_T    = 2'h2,
        STRONG_T  = 2'h3
    } PHT_STATE;

    typedef struct packed {
        ADDR  PC;
        logic taken;
    } PC_ENTRY;

    typedef struct packed {
        logic valid;
        INST  inst;
        ADDR  PC;
        ADDR  NPC;
        logic predict_taken;
        ADDR  predict_target;
    } IF_ID_PACKET;

    // One resolved branch from the reorder buffer
    typedef struct packed {
        logic valid;
        ADDR  PC;
        logic taken;
        ADDR  resolve_target;
        logic success;
    } ROB_IF_ENTRY;

    typedef struct packed {
        ROB_IF_ENTRY [FETCH_WIDTH-1:0] entries;
    } ROB_IF_PACKET;

endpackage

/* branch_predictor.sv */
`timescale 1ns/10ps

module branch_predictor import fetch_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,
    input  ADDR                       pc_start,
    input  ROB_IF_PACKET              rob_if_packet,
    output PC_ENTRY [FETCH_WIDTH-1:0] target_pc
);

    typedef struct packed {
        logic                    valid;
        logic [BTB_TAG_BITS-1:0] tag;
        ADDR                     target;
    } btb_entry;

    btb_entry               btb [BTB_SIZE];
    logic [BHT_WIDTH-1:0]   bht [BHT_SIZE];
    PHT_STATE               pht [PHT_SIZE];

    ADDR  [FETCH_WIDTH-1:0] slot_pc;
    logic [FETCH_WIDTH-1:0] btb_hit;
    logic [FETCH_WIDTH-1:0] pht_taken;

    function automatic logic [BTB_INDEX_BITS-1:0] btb_index(ADDR pc);
        return pc[2 +: BTB_INDEX_BITS];
    endfunction

    function automatic logic [BTB_TAG_BITS-1:0] btb_tag(ADDR pc);
        return pc[31 -: BTB_TAG_BITS];
    endfunction

    function automatic logic [BHT_INDEX_BITS-1:0] bht_index(ADDR pc);
        return pc[2 +: BHT_INDEX_BITS];
    endfunction

    // Saturating two-bit counter step
    function automatic PHT_STATE pht_step(PHT_STATE state, logic taken);
        case (state)
            STRONG_NT: return taken ? WEAK_NT  : STRONG_NT;
            WEAK_NT:   return taken ? WEAK_T   : STRONG_NT;
            WEAK_T:    return taken ? STRONG_T : WEAK_NT;
            default:   return taken ? STRONG_T : WEAK_T;
        endcase
    endfunction

    // Each slot predicts from the one before it
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (i == 0) begin
                slot_pc[i] = pc_start;
            end else begin
                slot_pc[i] = target_pc[i-1].PC;
            end

            btb_hit[i] = btb[btb_index(slot_pc[i])].valid &&
                         (btb[btb_index(slot_pc[i])].tag == btb_tag(slot_pc[i]));
            pht_taken[i] = pht[bht[bht_index(slot_pc[i])]] inside {WEAK_T, STRONG_T};

            target_pc[i].taken = btb_hit[i] && pht_taken[i];
            if (target_pc[i].taken) begin
                target_pc[i].PC = btb[btb_index(slot_pc[i])].target;
            end else begin
                target_pc[i].PC = slot_pc[i] + 32'd4;
            end
        end
    end

    // Training, later ROB entries overwrite earlier ones
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int j = 0; j < BTB_SIZE; j++) begin
                btb[j].valid <= 1'b0;
            end
            for (int j = 0; j < BHT_SIZE; j++) begin
                bht[j] <= '0;
            end
            for (int j = 0; j < PHT_SIZE; j++) begin
                pht[j] <= WEAK_NT;
            end
        end else begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                if (rob_if_packet.entries[i].valid) begin
                    bht[bht_index(rob_if_packet.entries[i].PC)] <= {
                        bht[bht_index(rob_if_packet.entries[i].PC)][BHT_WIDTH-2:0],
                        rob_if_packet.entries[i].taken
                    };
                    pht[bht[bht_index(rob_if_packet.entries[i].PC)]] <= pht_step(
                        pht[bht[bht_index(rob_if_packet.entries[i].PC)]],
                        rob_if_packet.entries[i].taken
                    );
                    if (rob_if_packet.entries[i].taken) begin
                        btb[btb_index(rob_if_packet.entries[i].PC)] <= '{
                            valid:  1'b1,
                            tag:    btb_tag(rob_if_packet.entries[i].PC),
                            target: rob_if_packet.entries[i].resolve_target
                        };
                    end
                end
            end
        end
    end

    // Resolved targets from the ROB and the start PC must keep fetch word aligned
    for (genvar i = 0; i < FETCH_WIDTH; i++) begin : g_align_check
        assert property (@(posedge clock) disable iff (reset)
            target_pc[i].PC[1:0] == 2'b00)
        else $error("branch_predictor: misaligned target in slot %0d", i);
    end

endmodule

/* icache.sv */
`timescale 1ns/10ps

module icache import fetch_pkg::*; (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       squash,
    input  logic                       dcache_request,
    input  MEM_TAG                     mem2proc_transaction_tag,
    input  MEM_TAG                     mem2proc_data_tag,
    input  MEM_BLOCK                   mem2proc_data,
    input  ADDR      [FETCH_WIDTH-1:0] proc2Icache_addr,
    input  logic     [FETCH_WIDTH-1:0] proc2Icache_valid,
    output MEM_COMMAND                 proc2Imem_command,
    output ADDR                        proc2Imem_addr,
    output MEM_BLOCK [FETCH_WIDTH-1:0] Icache_data_out,
    output logic     [FETCH_WIDTH-1:0] Icache_valid_out
);

    // One outstanding miss, keyed by its memory tag
    typedef struct packed {
        logic        valid;
        MEM_TAG      mem_tag;
        ICACHE_TAG   line_tag;
        ICACHE_INDEX index;
    } imshr_entry;

    logic [ICACHE_LINES-1:0] line_valid;
    ICACHE_TAG               line_tag  [ICACHE_LINES];
    MEM_BLOCK                line_data [ICACHE_LINES];

    imshr_entry [IMSHR_SIZE-1:0] imshr;

    ICACHE_INDEX [FETCH_WIDTH-1:0] req_index;
    ICACHE_TAG   [FETCH_WIDTH-1:0] req_tag;
    logic        [FETCH_WIDTH-1:0] in_flight;
    logic        [IMSHR_SIZE-1:0]  fill_hit;

    logic                        miss_found;
    logic                        free_found;
    logic [IMSHR_INDEX_BITS-1:0] free_slot;
    logic                        issue;
    logic                        accepted;
    ICACHE_INDEX                 issue_index;
    ICACHE_TAG                   issue_tag;

    // Lookup, hits return in the same cycle
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            req_index[i] = proc2Icache_addr[i][BLOCK_OFFSET_BITS +: ICACHE_INDEX_BITS];
            req_tag[i]   = proc2Icache_addr[i][31 -: ICACHE_TAG_BITS];

            Icache_data_out[i]  = line_data[req_index[i]];
            Icache_valid_out[i] = proc2Icache_valid[i] && line_valid[req_index[i]] &&
                                  (line_tag[req_index[i]] == req_tag[i]);

            in_flight[i] = 1'b0;
            for (int m = 0; m < IMSHR_SIZE; m++) begin
                if (imshr[m].valid && imshr[m].index == req_index[i] &&
                    imshr[m].line_tag == req_tag[i]) begin
                    in_flight[i] = 1'b1;
                end
            end
        end
    end

    // Pick the lowest free register and the lowest uncovered miss
    always_comb begin
        free_found = 1'b0;
        free_slot  = '0;
        for (int m = IMSHR_SIZE - 1; m >= 0; m--) begin
            if (!imshr[m].valid) begin
                free_found = 1'b1;
                free_slot  = IMSHR_INDEX_BITS'(m);
            end
        end

        miss_found  = 1'b0;
        issue_index = '0;
        issue_tag   = '0;
        for (int i = FETCH_WIDTH - 1; i >= 0; i--) begin
            if (proc2Icache_valid[i] && !Icache_valid_out[i] && !in_flight[i]) begin
                miss_found  = 1'b1;
                issue_index = req_index[i];
                issue_tag   = req_tag[i];
            end
        end

        // The data cache owns the port whenever it asks
        issue             = miss_found && free_found && !dcache_request;
        proc2Imem_command = issue ? LOAD : NONE;
        proc2Imem_addr    = {issue_tag, issue_index, {BLOCK_OFFSET_BITS{1'b0}}};
    end

    assign accepted = issue && (mem2proc_transaction_tag != '0);

    always_comb begin
        for (int m = 0; m < IMSHR_SIZE; m++) begin
            fill_hit[m] = imshr[m].valid && (mem2proc_data_tag != '0) &&
                          (imshr[m].mem_tag == mem2proc_data_tag);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else begin
            for (int m = 0; m < IMSHR_SIZE; m++) begin
                if (fill_hit[m]) begin
                    line_valid[imshr[m].index] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int m = 0; m < IMSHR_SIZE; m++) begin
            if (fill_hit[m]) begin
                line_tag[imshr[m].index]  <= imshr[m].line_tag;
                line_data[imshr[m].index] <= mem2proc_data;
            end
        end
    end

    // Squash forgets every outstanding miss, late fills find no match
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            for (int m = 0; m < IMSHR_SIZE; m++) begin
                imshr[m].valid <= 1'b0;
            end
        end else begin
            for (int m = 0; m < IMSHR_SIZE; m++) begin
                if (fill_hit[m]) begin
                    imshr[m].valid <= 1'b0;
                end
            end
            if (accepted) begin
                imshr[free_slot] <= '{
                    valid:    1'b1,
                    mem_tag:  mem2proc_transaction_tag,
                    line_tag: issue_tag,
                    index:    issue_index
                };
            end
        end
    end

    // Memory must never hand out a tag that is still live
    for (genvar a = 0; a < IMSHR_SIZE; a++) begin : g_tag_unique
        for (genvar b = a + 1; b < IMSHR_SIZE; b++) begin : g_pair
            assert property (@(posedge clock) disable iff (reset)
                !(imshr[a].valid && imshr[b].valid && imshr[a].mem_tag == imshr[b].mem_tag))
            else $error("icache: registers %0d and %0d share a memory tag", a, b);
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        (proc2Imem_command == LOAD) |-> !dcache_request)
    else $error("icache: LOAD issued while the data cache holds the port");

endmodule

/* stage_fetch.sv */
`timescale 1ns/10ps

module stage_fetch import fetch_pkg::*; (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          stall,
    input  logic                          squash,
    input  logic                          dcache_request,
    input  MEM_TAG                        mem2proc_transaction_tag,
    input  MEM_TAG                        mem2proc_data_tag,
    input  MEM_BLOCK                      mem2proc_data,
    input  ROB_IF_PACKET                  rob_if_packet,
    output MEM_COMMAND                    proc2Imem_command,
    output ADDR                           proc2Imem_addr,
    output IF_ID_PACKET [FETCH_WIDTH-1:0] if_id_packet
);

    ADDR pc_start;
    ADDR next_pc_start;

    PC_ENTRY  [FETCH_WIDTH-1:0] target_pc;
    ADDR      [FETCH_WIDTH-1:0] proc2Icache_addr;
    logic     [FETCH_WIDTH-1:0] proc2Icache_valid;
    MEM_BLOCK [FETCH_WIDTH-1:0] Icache_data_out;
    logic     [FETCH_WIDTH-1:0] Icache_valid_out;
    logic     [FETCH_WIDTH-1:0] slot_valid;

    logic redirect;
    ADDR  redirect_pc;

    branch_predictor branch_predictor_inst (
        .clock         (clock),
        .reset         (reset),
        .pc_start      (pc_start),
        .rob_if_packet (rob_if_packet),
        .target_pc     (target_pc)
    );

    icache icache_inst (
        .clock                    (clock),
        .reset                    (reset),
        .squash                   (squash),
        .dcache_request           (dcache_request),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc_data_tag        (mem2proc_data_tag),
        .mem2proc_data            (mem2proc_data),
        .proc2Icache_addr         (proc2Icache_addr),
        .proc2Icache_valid        (proc2Icache_valid),
        .proc2Imem_command        (proc2Imem_command),
        .proc2Imem_addr           (proc2Imem_addr),
        .Icache_data_out          (Icache_data_out),
        .Icache_valid_out         (Icache_valid_out)
    );

    // Mispredict from the ROB, the higher slot wins
    always_comb begin
        redirect    = 1'b0;
        redirect_pc = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (rob_if_packet.entries[i].valid && !rob_if_packet.entries[i].success) begin
                redirect    = 1'b1;
                redirect_pc = rob_if_packet.entries[i].resolve_target;
            end
        end
    end

    // Slot 0 fetches pc_start, later slots follow the predicted chain
    always_comb begin
        proc2Icache_addr[0] = pc_start;
        for (int i = 1; i < FETCH_WIDTH; i++) begin
            proc2Icache_addr[i] = target_pc[i-1].PC;
        end
        proc2Icache_valid = {FETCH_WIDTH{!redirect}};
    end

    // Valid slots stay contiguous from slot 0
    always_comb begin
        logic chain;

        chain = 1'b1;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            slot_valid[i] = chain && Icache_valid_out[i];
            chain         = slot_valid[i];
        end
    end

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if_id_packet[i].valid          = slot_valid[i];
            if_id_packet[i].PC             = proc2Icache_addr[i];
            if_id_packet[i].NPC            = proc2Icache_addr[i] + 32'd4;
            if_id_packet[i].predict_taken  = target_pc[i].taken;
            if_id_packet[i].predict_target = target_pc[i].PC;
            if (!slot_valid[i]) begin
                if_id_packet[i].inst = NOP;
            end else if (proc2Icache_addr[i][2]) begin
                if_id_packet[i].inst = Icache_data_out[i][63:32];
            end else begin
                if_id_packet[i].inst = Icache_data_out[i][31:0];
            end
        end
    end

    // Advance past the last valid slot, a redirect is never held back
    always_comb begin
        next_pc_start = pc_start;
        if (!stall) begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                if (slot_valid[i]) begin
                    next_pc_start = target_pc[i].PC;
                end
            end
        end
        if (redirect) begin
            next_pc_start = redirect_pc;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_start <= '0;
        end else begin
            pc_start <= next_pc_start;
        end
    end

endmodule

/* fetch_tb_memory.sv */
`timescale 1ns/10ps

module fetch_tb_memory import fetch_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  MEM_COMMAND proc2Imem_command,
    input  ADDR        proc2Imem_addr,
    output MEM_TAG     mem2proc_transaction_tag,
    output MEM_TAG     mem2proc_data_tag,
    output MEM_BLOCK   mem2proc_data
);

    localparam int  MAX_PENDING = 4;
    localparam INST PATTERN     = 32'hA5A5_0000;

    logic   pend_valid [MAX_PENDING];
    MEM_TAG pend_tag   [MAX_PENDING];
    ADDR    pend_addr  [MAX_PENDING];
    int     pend_wait  [MAX_PENDING];
    MEM_TAG next_tag;
    int     pend_count;
    int     free_slot;
    int     seed;

    initial seed = 11596;

    // Two instructions per block, each one its own address xor the pattern
    function automatic MEM_BLOCK block_at(ADDR addr);
        ADDR base;

        base = {addr[31:3], 3'b000};
        return {(base + 32'd4) ^ PATTERN, base ^ PATTERN};
    endfunction

    always_comb begin
        pend_count = 0;
        free_slot  = 0;
        for (int s = MAX_PENDING - 1; s >= 0; s--) begin
            if (pend_valid[s]) begin
                pend_count++;
            end else begin
                free_slot = s;
            end
        end
    end

    // Accept in the same cycle while there is room
    assign mem2proc_transaction_tag =
        (!reset && proc2Imem_command == LOAD && pend_count < MAX_PENDING) ? next_tag : '0;

    always @(posedge clock) begin
        logic sent;

        if (reset) begin
            for (int s = 0; s < MAX_PENDING; s++) begin
                pend_valid[s] <= 1'b0;
            end
            next_tag          <= 4'h1;
            mem2proc_data_tag <= '0;
            mem2proc_data     <= '0;
        end else begin
            sent = 1'b0;
            mem2proc_data_tag <= '0;
            // At most one response per cycle, others wait their turn
            for (int s = 0; s < MAX_PENDING; s++) begin
                if (pend_valid[s] && pend_wait[s] == 0 && !sent) begin
                    mem2proc_data_tag <= pend_tag[s];
                    mem2proc_data     <= block_at(pend_addr[s]);
                    pend_valid[s]     <= 1'b0;
                    sent = 1'b1;
                end else if (pend_valid[s] && pend_wait[s] > 0) begin
                    pend_wait[s] <= pend_wait[s] - 1;
                end
            end
            if (mem2proc_transaction_tag != '0) begin
                pend_valid[free_slot] <= 1'b1;
                pend_tag[free_slot]   <= next_tag;
                pend_addr[free_slot]  <= proc2Imem_addr;
                pend_wait[free_slot]  <= 2 + (($random(seed) & 32'h7fff_ffff) % 6);
                next_tag <= (next_tag == 4'hF) ? 4'h1 : next_tag + 4'h1;
            end
        end
    end

endmodule

/* fetch_tb.sv */
`timescale 1ns/10ps

module fetch_tb import fetch_pkg::*; ();

    typedef enum logic [2:0] {
        STEP_FETCH, STEP_STALL, STEP_REDIRECT, STEP_TRAIN, STEP_DCACHE, STEP_SQUASH
    } step_kind;

    // kind, address, branch target, slots or cycles
    typedef struct packed {
        step_kind   kind;
        ADDR        addr;
        ADDR        target;
        logic [7:0] count;
    } step_row;

    localparam int      NUM_STEPS = 13;
    localparam int      MAX_WAIT  = 200;
    localparam step_row STEPS [NUM_STEPS] = '{
        '{STEP_FETCH,    32'h0,   32'h0,   8'd12},
        '{STEP_STALL,    32'h0,   32'h0,   8'd6},
        '{STEP_FETCH,    32'h0,   32'h0,   8'd6},
        '{STEP_REDIRECT, 32'h400, 32'h0,   8'd0},
        '{STEP_FETCH,    32'h0,   32'h0,   8'd6},
        '{STEP_TRAIN,    32'h110, 32'h200, 8'd5},
        '{STEP_REDIRECT, 32'h100, 32'h0,   8'd0},
        '{STEP_FETCH,    32'h0,   32'h0,   8'd10},
        '{STEP_REDIRECT, 32'h800, 32'h0,   8'd0},
        '{STEP_DCACHE,   32'h0,   32'h0,   8'd20},
        '{STEP_FETCH,    32'h0,   32'h0,   8'd4},
        '{STEP_SQUASH,   32'hC00, 32'h0,   8'd0},
        '{STEP_FETCH,    32'h0,   32'h0,   8'd4}
    };

    logic clock, reset, stall, squash, dcache_request;
    MEM_TAG mem2proc_transaction_tag, mem2proc_data_tag;
    MEM_BLOCK mem2proc_data;
    ROB_IF_PACKET rob_if_packet;
    MEM_COMMAND proc2Imem_command;
    ADDR proc2Imem_addr;
    IF_ID_PACKET [FETCH_WIDTH-1:0] if_id_packet;

    ADDR  exp_pc;
    int   fetched;
    logic trained;
    ADDR  train_pc;
    ADDR  train_target;

    stage_fetch stage_fetch_inst (.*);

    fetch_tb_memory memory_inst (
        .clock(clock), .reset(reset),
        .proc2Imem_command(proc2Imem_command), .proc2Imem_addr(proc2Imem_addr),
        .mem2proc_transaction_tag(mem2proc_transaction_tag),
        .mem2proc_data_tag(mem2proc_data_tag), .mem2proc_data(mem2proc_data)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic report_failure(string msg);
        $display("%s", msg);
        abort_run();
    endtask

    task automatic compare_addr(string name, ADDR actual, ADDR expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected 0x%08h actual 0x%08h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_inst(string name, INST actual, INST expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected 0x%08h actual 0x%08h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_command(string name, MEM_COMMAND actual, MEM_COMMAND expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_bit(string name, logic actual, logic expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
            abort_run();
        end
    endtask

    function automatic ADDR expected_next_pc(ADDR pc);
        return (trained && pc == train_pc) ? train_target : pc + 32'd4;
    endfunction

    function automatic ROB_IF_PACKET rob_entry(ADDR pc, logic taken, ADDR target, logic ok);
        ROB_IF_PACKET p;

        p = '0;
        p.entries[1] = '{valid: 1'b1, PC: pc, taken: taken, resolve_target: target, success: ok};
        return p;
    endfunction

    // Reference model of one cycle as seen at the falling edge
    task automatic check_packet();
        ADDR  pc;
        logic chain;
        logic redirect;
        ADDR  redirect_pc;
        int   advanced;
        ADDR  load_block;
        ADDR  next_block;

        pc = exp_pc;
        chain = 1'b1;
        advanced = 0;
        redirect = 1'b0;
        redirect_pc = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (rob_if_packet.entries[i].valid && !rob_if_packet.entries[i].success) begin
                redirect = 1'b1;
                redirect_pc = rob_if_packet.entries[i].resolve_target;
            end
        end
        if (dcache_request) begin
            compare_command("proc2Imem_command", proc2Imem_command, NONE);
        end
        if (redirect) begin
            compare_command("proc2Imem_command", proc2Imem_command, NONE);
        end else if (proc2Imem_command == LOAD) begin
            // Slot 0 block, or the block of its predicted successor
            load_block = exp_pc & 32'hFFFF_FFF8;
            next_block = expected_next_pc(exp_pc) & 32'hFFFF_FFF8;
            if (proc2Imem_addr == next_block) begin
                load_block = next_block;
            end
            compare_addr("proc2Imem_addr", proc2Imem_addr, load_block);
        end
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (!chain || !if_id_packet[i].valid) begin
                chain = 1'b0;
                if (if_id_packet[i].valid) begin
                    report_failure("A slot is valid after an invalid slot");
                end
                compare_inst("if_id_packet.inst", if_id_packet[i].inst, NOP);
            end else begin
                if (redirect) begin
                    report_failure("A slot is valid in a redirect cycle");
                end
                compare_addr("if_id_packet.PC", if_id_packet[i].PC, pc);
                compare_addr("if_id_packet.NPC", if_id_packet[i].NPC, pc + 32'd4);
                compare_inst("if_id_packet.inst", if_id_packet[i].inst, pc ^ 32'hA5A5_0000);
                compare_bit("if_id_packet.predict_taken", if_id_packet[i].predict_taken,
                            trained && pc == train_pc);
                compare_addr("if_id_packet.predict_target", if_id_packet[i].predict_target,
                             expected_next_pc(pc));
                pc = expected_next_pc(pc);
                advanced++;
            end
        end
        if (redirect) begin
            exp_pc = redirect_pc;
        end else if (!stall) begin
            exp_pc = pc;
            fetched += advanced;
        end
    endtask

    task automatic run_cycle(logic stall_v, logic dreq_v, logic squash_v, ROB_IF_PACKET rob_v);
        @(posedge clock);
        stall <= stall_v;
        dcache_request <= dreq_v;
        squash <= squash_v;
        rob_if_packet <= rob_v;
        @(negedge clock);
        check_packet();
    endtask

    task automatic fetch_slots(int count);
        int goal;
        int waited;

        goal = fetched + count;
        waited = 0;
        while (fetched < goal) begin
            if (waited == MAX_WAIT) begin
                report_failure("Timed out waiting for fetch to make progress");
            end
            run_cycle(1'b0, 1'b0, 1'b0, '0);
            waited++;
        end
    endtask

    // Squash right after the miss is accepted, then expect the LOAD again
    task automatic squash_miss(ADDR block);
        int   waited;
        logic reissued;

        run_cycle(1'b0, 1'b0, 1'b0, rob_entry(32'h0000_0ff0, 1'b0, block, 1'b0));
        waited = 0;
        while (!(proc2Imem_command == LOAD && proc2Imem_addr == block &&
                 mem2proc_transaction_tag != '0)) begin
            if (waited == MAX_WAIT) begin
                report_failure("Timed out waiting for the first LOAD of the squashed block");
            end
            run_cycle(1'b0, 1'b0, 1'b0, '0);
            waited++;
        end
        run_cycle(1'b0, 1'b0, 1'b1, '0);
        waited = 0;
        reissued = 1'b0;
        while (!reissued) begin
            if (waited == MAX_WAIT) begin
                report_failure("Timed out waiting for the LOAD to be issued again after squash");
            end
            run_cycle(1'b0, 1'b0, 1'b0, '0);
            if (if_id_packet[0].valid) begin
                report_failure("Squashed block came back valid without a new LOAD");
            end
            reissued = (proc2Imem_command == LOAD && proc2Imem_addr == block);
            waited++;
        end
    endtask

    initial begin
        reset = 1'b1;
        stall = 1'b0;
        squash = 1'b0;
        dcache_request = 1'b0;
        rob_if_packet = '0;
        exp_pc = '0;
        fetched = 0;
        trained = 1'b0;
        train_pc = '0;
        train_target = '0;
        repeat (5) @(posedge clock);
        reset <= 1'b0;

        for (int r = 0; r < NUM_STEPS; r++) begin
            case (STEPS[r].kind)
                STEP_FETCH: fetch_slots(STEPS[r].count);
                STEP_STALL: repeat (STEPS[r].count) run_cycle(1'b1, 1'b0, 1'b0, '0);
                STEP_REDIRECT: run_cycle(1'b0, 1'b0, 1'b0,
                    rob_entry(32'h0000_0ff0, 1'b0, STEPS[r].addr, 1'b0));
                STEP_TRAIN: begin
                    repeat (STEPS[r].count) begin
                        run_cycle(1'b1, 1'b0, 1'b0,
                            rob_entry(STEPS[r].addr, 1'b1, STEPS[r].target, 1'b1));
                    end
                    trained = 1'b1;
                    train_pc = STEPS[r].addr;
                    train_target = STEPS[r].target;
                end
                STEP_DCACHE: repeat (STEPS[r].count) run_cycle(1'b0, 1'b1, 1'b0, '0);
                default: squash_miss(STEPS[r].addr);
            endcase
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

/* sources.f */
fetch_pkg.sv
branch_predictor.sv
icache.sv
stage_fetch.sv
fetch_tb_memory.sv
fetch_tb.sv
